/* files.f */
+incdir+include
hw/cpuPkg.sv
hw/cpuControl.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/executeUnit.sv
hw/memoryWriteback.sv
hw/Processor.sv
testbench/Processor_assert.sv
testbench/ProcessorTb.sv

/* hw/Processor.sv */
`timescale 1ns/1ps
`default_nettype none

module Processor
  import cpuPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  logic     progWe,
  input  imemAddrT progAddr,
  input  dataWordT progData,
  output logic     halted,
  output logic     wbValid,
  output regAddrT  wbAddr,
  output dataWordT wbData,
  output ccrT      ccr
);

  logic     fetchEn;
  logic     immEn;
  logic     decodeEn;
  logic     executeEn;
  logic     memoryEn;
  logic     writebackEn;
  opcodeT   opcode;
  dataWordT instr;
  dataWordT immWord;
  decExT    decEx;
  exMemT    exMem;
  wbT       wb;

  cpuControl control (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .opcode      (opcode),
    .fetchEn     (fetchEn),
    .immEn       (immEn),
    .decodeEn    (decodeEn),
    .executeEn   (executeEn),
    .memoryEn    (memoryEn),
    .writebackEn (writebackEn),
    .halted      (halted)
  );

  fetchUnit fetch (
    .clk      (clk),
    .rst      (rst),
    .fetchEn  (fetchEn),
    .immEn    (immEn),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .instr    (instr),
    .immWord  (immWord),
    .opcode   (opcode)
  );

  decodeUnit decode (
    .clk         (clk),
    .rst         (rst),
    .decodeEn    (decodeEn),
    .writebackEn (writebackEn),
    .instr       (instr),
    .immWord     (immWord),
    .wb          (wb),
    .decEx       (decEx)
  );

  executeUnit execute (
    .clk       (clk),
    .rst       (rst),
    .executeEn (executeEn),
    .decEx     (decEx),
    .exMem     (exMem),
    .ccr       (ccr)
  );

  memoryWriteback memWb (
    .clk         (clk),
    .rst         (rst),
    .memoryEn    (memoryEn),
    .writebackEn (writebackEn),
    .exMem       (exMem),
    .wb          (wb),
    .wbValid     (wbValid),
    .wbAddr      (wbAddr),
    .wbData      (wbData)
  );

endmodule

`default_nettype wire

/* hw/cpuControl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuControl
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  opcodeT opcode,       // opcode field of the fetch register
  output logic   fetchEn,
  output logic   immEn,
  output logic   decodeEn,
  output logic   executeEn,
  output logic   memoryEn,
  output logic   writebackEn,
  output logic   halted
);

  cpuStateT state;
  cpuStateT stateNext;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= stateNext;
  end

  always_comb
  begin
    stateNext = state;
    case (state)
      IDLE:
        if (start)
          stateNext = FETCH;
      FETCH:
        stateNext = DECODE;   // fetch register valid from here on
      DECODE:
      begin
        if (opcode == HLT)
          stateNext = HALT;
        else if (opcode == LDM)
          stateNext = IMMFETCH;  // grab the second word first
        else
          stateNext = EXECUTE;
      end
      IMMFETCH:
        stateNext = EXECUTE;
      EXECUTE:
        stateNext = MEMORY;
      MEMORY:
        stateNext = WRITEBACK;
      WRITEBACK:
        stateNext = FETCH;
      HALT:
        stateNext = HALT;     // only rst leaves
      default:
        stateNext = IDLE;
    endcase
  end

  // one enable per state, so at most one is high
  assign fetchEn     = (state == FETCH);
  assign immEn       = (state == IMMFETCH);
  assign decodeEn    = (state == DECODE);
  assign executeEn   = (state == EXECUTE);
  assign memoryEn    = (state == MEMORY);
  assign writebackEn = (state == WRITEBACK);
  assign halted      = (state == HALT);

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

  typedef logic [`CPU_DATA_W-1:0] dataWordT;
  typedef logic [$clog2(`CPU_REG_CNT)-1:0] regAddrT;
  typedef logic [`CPU_IMEM_AW-1:0] imemAddrT;
  typedef logic [`CPU_DMEM_AW-1:0] dmemAddrT;
  typedef logic [2:0] ccrT;  // {carry, negative, zero}

  localparam int ccrZeroBit = 0;
  localparam int ccrNegBit = 1;
  localparam int ccrCarryBit = 2;

  typedef enum logic [4:0] {
    NOP = 5'd0,
    ADD = 5'd1,
    SUB = 5'd2,
    AND = 5'd3,
    OR  = 5'd4,
    NOT = 5'd5,
    MOV = 5'd6,
    LDM = 5'd7,   // immediate in the following word
    LDD = 5'd8,
    STD = 5'd9,
    HLT = 5'd10
  } opcodeT;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    IMMFETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALT
  } cpuStateT;

  // word layout: opcode[15:11] rd[10:8] rs[7:5] rt[4:2] spare[1:0]
  typedef struct packed {
    opcodeT opcode;
    regAddrT rd;
    regAddrT rs;
    regAddrT rt;
    logic [1:0] spare;
  } instrT;

  typedef struct packed {
    opcodeT opcode;
    dataWordT rsVal;
    dataWordT rtVal;
    dataWordT imm;
    regAddrT rd;
    logic regWrite;
    logic memRead;
    logic memWrite;
  } decExT;

  typedef struct packed {
    dataWordT result;
    dmemAddrT addr;
    dataWordT storeData;
    regAddrT rd;
    logic regWrite;
    logic memRead;
    logic memWrite;
  } exMemT;

  typedef struct packed {
    dataWordT value;
    regAddrT rd;
    logic regWrite;
  } wbT;

endpackage

`default_nettype wire

/* hw/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module decodeUnit
  import cpuPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     decodeEn,
  input  logic     writebackEn,
  input  dataWordT instr,
  input  dataWordT immWord,
  input  wbT       wb,
  output decExT    decEx
);

  instrT    fields;
  dataWordT regFile [0:`CPU_REG_CNT-1];
  logic     regWriteDec;
  logic     memReadDec;
  logic     memWriteDec;

  opcodeT   opReg;
  dataWordT rsValReg;
  dataWordT rtValReg;
  regAddrT  rdReg;
  logic     regWriteReg;
  logic     memReadReg;
  logic     memWriteReg;

  assign fields = instrT'(instr);

  always_comb
  begin
    regWriteDec = 1'b0;
    memReadDec  = 1'b0;
    memWriteDec = 1'b0;
    case (fields.opcode)
      ADD, SUB, AND, OR, NOT, MOV, LDM:
        regWriteDec = 1'b1;
      LDD:
      begin
        regWriteDec = 1'b1;
        memReadDec  = 1'b1;
      end
      STD:
        memWriteDec = 1'b1;
      default:
        regWriteDec = 1'b0;   // NOP, HLT
    endcase
  end

  // written at the end of WRITEBACK, never in the same cycle as a read
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CPU_REG_CNT; i++)
        regFile[i] <= '0;
    end
    else if (writebackEn && wb.regWrite)
      regFile[wb.rd] <= wb.value;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      opReg       <= NOP;
      regWriteReg <= 1'b0;
      memReadReg  <= 1'b0;
      memWriteReg <= 1'b0;
    end
    else if (decodeEn)
    begin
      opReg       <= fields.opcode;
      regWriteReg <= regWriteDec;
      memReadReg  <= memReadDec;
      memWriteReg <= memWriteDec;
    end
  end

  always_ff @(posedge clk)
  begin
    if (decodeEn)
    begin
      rsValReg <= regFile[fields.rs];
      rtValReg <= regFile[fields.rt];
      rdReg    <= fields.rd;
    end
  end

  // immediate comes straight from the fetch side register,
  // it is loaded in IMMFETCH which follows DECODE
  always_comb
  begin
    decEx.opcode   = opReg;
    decEx.rsVal    = rsValReg;
    decEx.rtVal    = rtValReg;
    decEx.imm      = immWord;
    decEx.rd       = rdReg;
    decEx.regWrite = regWriteReg;
    decEx.memRead  = memReadReg;
    decEx.memWrite = memWriteReg;
  end

endmodule

`default_nettype wire

/* hw/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module executeUnit
  import cpuPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  executeEn,
  input  decExT decEx,
  output exMemT exMem,
  output ccrT   ccr
);

  logic [`CPU_DATA_W:0] aluOut;   // extra bit is carry / borrow
  dataWordT result;
  logic aluOp;
  logic arithOp;

  always_comb
  begin
    case (decEx.opcode)
      ADD:     aluOut = {1'b0, decEx.rsVal} + {1'b0, decEx.rtVal};
      SUB:     aluOut = {1'b0, decEx.rsVal} - {1'b0, decEx.rtVal};
      AND:     aluOut = {1'b0, decEx.rsVal & decEx.rtVal};
      OR:      aluOut = {1'b0, decEx.rsVal | decEx.rtVal};
      NOT:     aluOut = {1'b0, ~decEx.rsVal};
      MOV:     aluOut = {1'b0, decEx.rsVal};
      LDM:     aluOut = {1'b0, decEx.imm};
      default: aluOut = '0;   // memory ops and NOP use no result
    endcase
  end

  assign result  = aluOut[`CPU_DATA_W-1:0];
  assign arithOp = (decEx.opcode == ADD) || (decEx.opcode == SUB);
  assign aluOp   = decEx.opcode inside {ADD, SUB, AND, OR, NOT};

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ccr   <= '0;
      exMem <= '0;
    end
    else if (executeEn)
    begin
      if (aluOp)
      begin
        ccr[ccrZeroBit] <= (result == '0);
        ccr[ccrNegBit]  <= result[`CPU_DATA_W-1];
        if (arithOp)
          ccr[ccrCarryBit] <= aluOut[`CPU_DATA_W];  // logic ops keep old carry
      end
      exMem.result    <= result;
      exMem.addr      <= decEx.rsVal[`CPU_DMEM_AW-1:0];
      exMem.storeData <= decEx.rtVal;
      exMem.rd        <= decEx.rd;
      exMem.regWrite  <= decEx.regWrite;
      exMem.memRead   <= decEx.memRead;
      exMem.memWrite  <= decEx.memWrite;
    end
  end

endmodule

`default_nettype wire

/* hw/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module fetchUnit
  import cpuPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fetchEn,
  input  logic     immEn,
  input  logic     progWe,
  input  imemAddrT progAddr,
  input  dataWordT progData,
  output dataWordT instr,
  output dataWordT immWord,
  output opcodeT   opcode
);

  dataWordT imem [0:(1 << `CPU_IMEM_AW)-1];
  imemAddrT pc;
  instrT    fields;

  // program load port, only used while idle
  always_ff @(posedge clk)
  begin
    if (progWe)
      imem[progAddr] <= progData;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc <= '0;
      instr <= '0;            // decodes as NOP
    end
    else
    begin
      if (fetchEn || immEn)
        pc <= pc + 1'b1;      // both fetches consume one word
      if (fetchEn)
        instr <= imem[pc];
    end
  end

  // second word of LDM
  always_ff @(posedge clk)
  begin
    if (immEn)
      immWord <= imem[pc];
  end

  assign fields = instrT'(instr);
  assign opcode = fields.opcode;

endmodule

`default_nettype wire

/* hw/memoryWriteback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module memoryWriteback
  import cpuPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     memoryEn,
  input  logic     writebackEn,
  input  exMemT    exMem,
  output wbT       wb,
  output logic     wbValid,
  output regAddrT  wbAddr,
  output dataWordT wbData
);

  dataWordT dmem [0:(1 << `CPU_DMEM_AW)-1];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < (1 << `CPU_DMEM_AW); i++)
        dmem[i] <= '0;        // unwritten words read back as zero
    end
    else if (memoryEn && exMem.memWrite)
      dmem[exMem.addr] <= exMem.storeData;
  end

  // synchronous read, picked against the ALU result
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      wb <= '0;
    else if (memoryEn)
    begin
      wb.value    <= exMem.memRead ? dmem[exMem.addr] : exMem.result;
      wb.rd       <= exMem.rd;
      wb.regWrite <= exMem.regWrite;
    end
  end

  // trace port, one cycle behind WRITEBACK
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wbValid <= 1'b0;
      wbAddr  <= '0;
      wbData  <= '0;
    end
    else
    begin
      wbValid <= writebackEn && wb.regWrite;
      if (writebackEn)
      begin
        wbAddr <= wb.rd;
        wbData <= wb.value;
      end
    end
  end

endmodule

`default_nettype wire

/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and instruction word width
`define CPU_DATA_W 16

// general purpose registers R0..R7
`define CPU_REG_CNT 8

// program memory holds 256 words
`define CPU_IMEM_AW 8

// data memory holds 256 words, addressed by the low byte of rs
`define CPU_DMEM_AW 8

`endif

/* run.sh */
#!/bin/sh
# builds and runs the Processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module ProcessorTb -f files.f

# the simulator status is not trusted on its own, the log decides
./obj_dir/VProcessorTb > sim.log 2>&1 || true
cat sim.log

grep -q "Test completed successfully" sim.log
echo "simulation passed"

/* testbench/ProcessorTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module ProcessorTb
  import cpuPkg::*;
();

  logic     clk;
  logic     rst;
  logic     start;
  logic     progWe;
  imemAddrT progAddr;
  dataWordT progData;
  logic     halted;
  logic     wbValid;
  regAddrT  wbAddr;
  dataWordT wbData;
  ccrT      ccr;

  // program image and reference model
  dataWordT prog [$];
  dataWordT refRegs [0:`CPU_REG_CNT-1];
  dataWordT refMem [0:(1 << `CPU_DMEM_AW)-1];
  ccrT      refCcr;
  regAddrT  expAddr [$];
  dataWordT expData [$];
  ccrT      expCcr [$];
  logic     halting;      // words after HLT are never executed

  integer seed;
  int instrCount;
  int errors = 0;
  int testsRun = 0;
  int testsPassed = 0;
  int cycleCount = 0;
  int cycleLimit = 16;    // grows with each test

  Processor dut (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .halted   (halted),
    .wbValid  (wbValid),
    .wbAddr   (wbAddr),
    .wbData   (wbData),
    .ccr      (ccr)
  );

  bind Processor Processor_assert checks (
    .clk         (clk),
    .rst         (rst),
    .fetchEn     (fetchEn),
    .immEn       (immEn),
    .decodeEn    (decodeEn),
    .executeEn   (executeEn),
    .memoryEn    (memoryEn),
    .writebackEn (writebackEn),
    .halted      (halted),
    .wbValid     (wbValid)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout, the processor did not halt within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic checkWord(input string sig, input dataWordT got, input dataWordT exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic checkReg(input string sig, input regAddrT got, input regAddrT exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is R%0d, expected R%0d", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlags(input string sig, input ccrT got, input ccrT exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, sig, got, exp);
      errors++;
    end
  endtask

  function automatic dataWordT randWord();
    return dataWordT'($random(seed));
  endfunction

  function automatic void newProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
    expCcr.delete();
    for (int i = 0; i < `CPU_REG_CNT; i++)
      refRegs[i] = '0;
    for (int i = 0; i < (1 << `CPU_DMEM_AW); i++)
      refMem[i] = '0;
    refCcr = '0;
    halting = 1'b0;
    instrCount = 0;
  endfunction

  // ALU and memory rules, one instruction at a time
  function automatic void modelOp(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt,
                                  dataWordT imm);
    dataWordT a;
    dataWordT b;
    dataWordT res;
    logic     carry;
    logic     writes;
    a = refRegs[rs];
    b = refRegs[rt];
    res = '0;
    carry = refCcr[ccrCarryBit];   // logic ops leave it alone
    writes = 1'b1;
    case (op)
      ADD:
      begin
        res = a + b;
        carry = (res < a);         // sum wrapped past the top
      end
      SUB:
      begin
        res = a - b;
        carry = (a < b);           // borrow
      end
      AND: res = a & b;
      OR:  res = a | b;
      NOT: res = ~a;
      MOV: res = a;
      LDM: res = imm;
      LDD: res = refMem[a[`CPU_DMEM_AW-1:0]];
      STD:
      begin
        refMem[a[`CPU_DMEM_AW-1:0]] = b;
        writes = 1'b0;
      end
      default: writes = 1'b0;      // NOP
    endcase
    if (op inside {ADD, SUB, AND, OR, NOT})
    begin
      refCcr[ccrZeroBit] = (res == '0);
      refCcr[ccrNegBit] = res[`CPU_DATA_W-1];
      refCcr[ccrCarryBit] = carry;
    end
    if (writes)
    begin
      refRegs[rd] = res;
      expAddr.push_back(rd);
      expData.push_back(res);
      expCcr.push_back(refCcr);
    end
  endfunction

  function automatic void putOp(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt);
    prog.push_back({op, rd, rs, rt, 2'b00});
    instrCount++;
    if (!halting)
      modelOp(op, rd, rs, rt, '0);
  endfunction

  function automatic void loadImm(regAddrT rd, dataWordT imm);
    prog.push_back({LDM, rd, 3'd0, 3'd0, 2'b00});
    prog.push_back(imm);           // second word
    instrCount++;
    if (!halting)
      modelOp(LDM, rd, 3'd0, 3'd0, imm);
  endfunction

  function automatic void haltHere();
    prog.push_back({HLT, 11'd0});
    instrCount++;
    halting = 1'b1;
  endfunction

  task automatic applyReset();
    @(negedge clk);
    rst = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic writeProgram();
    for (int i = 0; i < prog.size(); i++)
    begin
      @(negedge clk);
      progWe = 1'b1;
      progAddr = imemAddrT'(i);
      progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
  endtask

  task automatic runAndCompare(input string name);
    int errorsBefore;
    int seen;
    errorsBefore = errors;
    seen = 0;
    cycleLimit += 2 * (6 * instrCount + 5 + prog.size() + 12);
    applyReset();
    if (halted || wbValid)
    begin
      $display("%s: halted or wbValid is high right after reset", name);
      errors++;
    end
    checkFlags("ccr after reset", ccr, '0);
    writeProgram();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!halted)
    begin
      @(negedge clk);
      if (wbValid)
      begin
        if (seen < expAddr.size())
        begin
          checkReg($sformatf("wbAddr #%0d", seen), wbAddr, expAddr[seen]);
          checkWord($sformatf("wbData #%0d", seen), wbData, expData[seen]);
          checkFlags($sformatf("ccr #%0d", seen), ccr, expCcr[seen]);
        end
        seen++;
      end
    end
    // nothing may follow HLT
    repeat (6)
    begin
      @(negedge clk);
      if (wbValid || !halted)
      begin
        $display("%s: activity after halt at %0t ns", name, $time);
        errors++;
      end
    end
    if (seen != expAddr.size())
    begin
      $display("%s: expected %0d write-backs but %0d arrived", name, expAddr.size(), seen);
      errors++;
    end
    testsRun++;
    if (errors == errorsBefore)
      testsPassed++;
    $display("%s: %s, %0d write-backs", name, (errors == errorsBefore) ? "ok" : "FAILED", seen);
  endtask

  task automatic loadAllRegisters();
    newProgram();
    for (int r = 0; r < `CPU_REG_CNT; r++)
      loadImm(regAddrT'(r), randWord());
    haltHere();
    runAndCompare("loadAllRegisters");
  endtask

  task automatic aluOpsAndFlags();
    newProgram();
    loadImm(3'd1, randWord());
    loadImm(3'd2, randWord());
    loadImm(3'd5, randWord() & 16'h7fff);  // below r6
    loadImm(3'd6, randWord() | 16'h8000);
    putOp(ADD, 3'd3, 3'd1, 3'd2);
    putOp(SUB, 3'd4, 3'd1, 3'd2);
    putOp(AND, 3'd3, 3'd1, 3'd2);
    putOp(OR, 3'd4, 3'd1, 3'd2);
    putOp(NOT, 3'd3, 3'd1, 3'd0);
    putOp(MOV, 3'd4, 3'd2, 3'd0);
    putOp(SUB, 3'd0, 3'd5, 3'd6);          // borrow
    putOp(NOT, 3'd7, 3'd5, 3'd0);          // negative, borrow kept
    putOp(ADD, 3'd7, 3'd6, 3'd6);          // carry out
    putOp(SUB, 3'd4, 3'd1, 3'd1);          // zero
    putOp(OR, 3'd3, 3'd4, 3'd4);
    haltHere();
    runAndCompare("aluOpsAndFlags");
  endtask

  task automatic storeThenLoad();
    dataWordT addr;
    addr = randWord();
    newProgram();
    loadImm(3'd1, addr);
    loadImm(3'd2, randWord());
    putOp(STD, 3'd0, 3'd1, 3'd2);
    putOp(NOP, 3'd0, 3'd0, 3'd0);
    putOp(LDD, 3'd3, 3'd1, 3'd0);
    loadImm(3'd4, addr ^ 16'h005a);        // other low byte, never written
    putOp(LDD, 3'd5, 3'd4, 3'd0);
    haltHere();
    runAndCompare("storeThenLoad");
  endtask

  task automatic haltStopsIssue();
    newProgram();
    loadImm(3'd1, randWord());
    putOp(NOP, 3'd0, 3'd0, 3'd0);
    putOp(MOV, 3'd2, 3'd1, 3'd0);
    haltHere();
    loadImm(3'd3, randWord());
    putOp(MOV, 3'd4, 3'd1, 3'd0);
    putOp(ADD, 3'd5, 3'd1, 3'd1);
    runAndCompare("haltStopsIssue");
  endtask

  task automatic restartAfterHalt();
    if (!halted)
    begin
      $display("restartAfterHalt: processor was not halted before the reset");
      errors++;
    end
    newProgram();
    putOp(MOV, 3'd3, 3'd1, 3'd0);          // r1 held data before reset
    putOp(MOV, 3'd4, 3'd2, 3'd0);
    loadImm(3'd5, randWord());
    putOp(MOV, 3'd6, 3'd5, 3'd0);
    haltHere();
    runAndCompare("restartAfterHalt");
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    seed = 32'h421f_3c6e;
    loadAllRegisters();
    aluOpsAndFlags();
    storeThenLoad();
    haltStopsIssue();
    restartAfterHalt();
    $display("%0d tests run, %0d passed, %0d errors", testsRun, testsPassed, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/Processor_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module Processor_assert (
  input logic clk,
  input logic rst,
  input logic fetchEn,
  input logic immEn,
  input logic decodeEn,
  input logic executeEn,
  input logic memoryEn,
  input logic writebackEn,
  input logic halted,
  input logic wbValid
);

  // one stage active per cycle, none in IDLE or HALT
  enableOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({fetchEn, immEn, decodeEn, executeEn, memoryEn, writebackEn}))
    else $error("stage enables are not one-hot");

  noWbWhileHalted: assert property (@(posedge clk) disable iff (rst)
    halted |-> !$rose(wbValid))
    else $error("wbValid rose while halted");

  // only rst leaves HALT
  haltSticky: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted)
    else $error("halted dropped without reset");

endmodule

`default_nettype wire
